/* source/ex_pkg.sv */
package ex_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int unsigned XLEN       = 32;  // Data word width
  localparam int unsigned REG_ADDR_W = 6;   // MSB selects the FP register bank

  ////////////////////////////////////////
  // Operation word
  ////////////////////////////////////////

  // ALU view of the 7-bit operation word
  typedef enum logic [6:0] {
    ALU_ADD  = 7'b0011000,
    ALU_SUB  = 7'b0011001,
    ALU_AND  = 7'b0010101,
    ALU_OR   = 7'b0101110,
    ALU_XOR  = 7'b0101111,
    ALU_SLL  = 7'b0100111,
    ALU_SRL  = 7'b0100101,
    ALU_SRA  = 7'b0100100,
    ALU_SLT  = 7'b0000010,  // Signed set-less-than
    ALU_SLTU = 7'b0000011,  // Unsigned set-less-than
    ALU_EQ   = 7'b0001100,
    ALU_NE   = 7'b0001101,
    ALU_LTS  = 7'b0000000,
    ALU_LTU  = 7'b0000001,
    ALU_GES  = 7'b0001010,
    ALU_GEU  = 7'b0001011
  } alu_opcode_e;

  // Multiplier view of the same word
  typedef struct packed {
    logic       hi;        // Return upper half of the product
    logic       a_signed;  // Operand A is signed
    logic       b_signed;  // Operand B is signed
    logic [3:0] spare;     // Must be zero
  } mul_view_t;

  // One word, read by whichever unit is enabled
  typedef union packed {
    alu_opcode_e alu;
    mul_view_t   mul;
  } ex_op_u;

  ////////////////////////////////////////
  // Port bundles
  ////////////////////////////////////////

  typedef struct packed {
    logic            en;
    ex_op_u          op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;  // Jump target for branches
  } alu_req_t;

  typedef struct packed {
    logic            en;
    ex_op_u          op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } mult_req_t;

  // Register file write port
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } wb_port_t;

  // Result returned by a functional unit
  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            ready;       // Result valid this cycle
    logic            multicycle;  // Unit needs more cycles
  } unit_res_t;

endpackage

/* source/ex_alu.sv */
`timescale 1ns/100ps

module ex_alu (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_pkg::alu_req_t        req_i,
  output ex_pkg::unit_res_t       res_o,
  output logic                    branch_decision_o,
  output logic [ex_pkg::XLEN-1:0] jump_target_o
);

  // Clock and reset reserved for future multicycle ops

  ex_pkg::alu_opcode_e     opcode;
  logic [ex_pkg::XLEN-1:0] op_a;
  logic [ex_pkg::XLEN-1:0] op_b;
  logic [ex_pkg::XLEN:0]   diff;       // A - B with carry out
  logic                    lt_u;
  logic                    lt_s;
  logic                    eq;
  logic [4:0]              shamt;
  logic [ex_pkg::XLEN-1:0] shift_res;
  logic                    cmp;
  logic [ex_pkg::XLEN-1:0] result;

  assign opcode = req_i.op.alu;  // ALU reading of the op word
  assign op_a   = req_i.a;
  assign op_b   = req_i.b;

  ////////////////////////////////////////
  // Shared subtractor and compares
  ////////////////////////////////////////

  assign diff = {1'b0, op_a} + {1'b0, ~op_b} + 1'b1;
  assign lt_u = ~diff[ex_pkg::XLEN];  // No carry out means borrow
  // Same signs give the unsigned answer, else A's sign decides
  assign lt_s = (op_a[ex_pkg::XLEN-1] == op_b[ex_pkg::XLEN-1]) ? lt_u
                                                               : op_a[ex_pkg::XLEN-1];
  assign eq   = (op_a == op_b);

  always_comb begin
    case (opcode)
      ex_pkg::ALU_EQ:   cmp = eq;
      ex_pkg::ALU_NE:   cmp = ~eq;
      ex_pkg::ALU_LTS,
      ex_pkg::ALU_SLT:  cmp = lt_s;
      ex_pkg::ALU_LTU,
      ex_pkg::ALU_SLTU: cmp = lt_u;
      ex_pkg::ALU_GES:  cmp = ~lt_s;
      ex_pkg::ALU_GEU:  cmp = ~lt_u;
      default:          cmp = 1'b0;  // Not a compare
    endcase
  end

  ////////////////////////////////////////
  // Barrel shifter
  ////////////////////////////////////////

  assign shamt = op_b[4:0];  // Only low 5 bits count

  always_comb begin
    case (opcode)
      ex_pkg::ALU_SLL: shift_res = op_a << shamt;
      ex_pkg::ALU_SRA: shift_res = $unsigned($signed(op_a) >>> shamt);
      default:         shift_res = op_a >> shamt;  // SRL
    endcase
  end

  // Result select
  always_comb begin
    case (opcode)
      ex_pkg::ALU_ADD: result = op_a + op_b;  // Wraps on overflow
      ex_pkg::ALU_SUB: result = diff[ex_pkg::XLEN-1:0];
      ex_pkg::ALU_AND: result = op_a & op_b;
      ex_pkg::ALU_OR:  result = op_a | op_b;
      ex_pkg::ALU_XOR: result = op_a ^ op_b;
      ex_pkg::ALU_SLL,
      ex_pkg::ALU_SRL,
      ex_pkg::ALU_SRA: result = shift_res;
      default:         result = {{(ex_pkg::XLEN-1){1'b0}}, cmp};  // Compares and SLT
    endcase
  end

  assign res_o.result     = result;
  assign res_o.ready      = 1'b1;  // Single cycle
  assign res_o.multicycle = 1'b0;

  // Branch outputs
  assign branch_decision_o = cmp;
  assign jump_target_o     = req_i.c;  // Target computed in ID

endmodule

/* source/ex_mult.sv */
`timescale 1ns/100ps

module ex_mult (
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::mult_req_t req_i,
  input  logic              ex_ready_i,
  output ex_pkg::unit_res_t res_o
);

  ex_pkg::mul_view_t         view;
  logic [ex_pkg::XLEN:0]     op_a_ext;   // 33 bit, sign or zero extended
  logic [ex_pkg::XLEN:0]     op_b_ext;
  logic [2*ex_pkg::XLEN-1:0] prod;       // Full 64-bit product
  logic [ex_pkg::XLEN-1:0]   prod_hi_q;  // Upper half held for cycle two
  logic                      busy_q;     // High-half result is waiting
  logic                      hi_start;

  assign view = req_i.op.mul;  // Multiplier reading of the op word

  ////////////////////////////////////////
  // Operand extension and product
  ////////////////////////////////////////

  // Extra MSB is a copy of the sign only when that operand is signed
  assign op_a_ext = {view.a_signed & req_i.a[ex_pkg::XLEN-1], req_i.a};
  assign op_b_ext = {view.b_signed & req_i.b[ex_pkg::XLEN-1], req_i.b};

  // 33x33 signed multiply, low 64 bits are exact for all sign modes
  assign prod = $signed(op_a_ext) * $signed(op_b_ext);

  // A high-half request seen while idle starts the second cycle
  assign hi_start = req_i.en & view.hi & ~busy_q;

  ////////////////////////////////////////
  // Two-cycle control
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (hi_start) begin
      busy_q <= 1'b1;  // Result presented next cycle
    end else if (busy_q && ex_ready_i) begin
      busy_q <= 1'b0;  // Consumed by the stage
    end
  end

  always_ff @(posedge clk) begin
    if (hi_start) begin
      prod_hi_q <= prod[2*ex_pkg::XLEN-1:ex_pkg::XLEN];
    end
  end

  // Low half is combinational; upper half comes from the register
  assign res_o.result     = busy_q ? prod_hi_q : prod[ex_pkg::XLEN-1:0];
  assign res_o.ready      = ~hi_start;  // Held low during first cycle
  assign res_o.multicycle = hi_start;

endmodule

/* source/ex_writeback.sv */
`timescale 1ns/100ps

module ex_writeback (
  input  logic                          clk,
  input  logic                          rst_n,
  input  ex_pkg::unit_res_t             alu_res_i,
  input  ex_pkg::unit_res_t             mult_res_i,
  input  logic                          alu_en_i,
  input  logic                          mult_en_i,
  input  logic                          csr_access_i,
  input  logic                          lsu_en_i,
  input  logic                          lsu_ready_ex_i,  // EX part of LSU done
  input  logic                          lsu_err_i,
  input  logic                          branch_in_ex_i,
  input  logic                          wb_ready_i,      // WB can take data
  input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,
  input  logic [ex_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                          alu_we_i,
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] alu_waddr_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_i,
  output ex_pkg::wb_port_t              fw_port_o,
  output ex_pkg::wb_port_t              wb_port_o,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o
);

  logic                          units_ready;
  logic                          lsu_we;      // Write enable minus load error
  logic                          lsu_we_q;
  logic [ex_pkg::REG_ADDR_W-1:0] lsu_waddr_q;

  ////////////////////////////////////////
  // Forward port
  ////////////////////////////////////////

  // CSR wins over multiplier, multiplier over ALU
  always_comb begin
    fw_port_o.we   = alu_we_i;
    fw_port_o.addr = alu_waddr_i;
    fw_port_o.data = '0;
    if (csr_access_i) begin
      fw_port_o.data = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_port_o.data = mult_res_i.result;
    end else if (alu_en_i) begin
      fw_port_o.data = alu_res_i.result;
    end
  end

  ////////////////////////////////////////
  // EX/WB register for the LSU port
  ////////////////////////////////////////

  assign lsu_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_o) begin  // Implies wb_ready_i
      lsu_we_q <= lsu_we;
      if (lsu_we) lsu_waddr_q <= regfile_waddr_i;  // Keep last address otherwise
    end else if (wb_ready_i) begin
      lsu_we_q <= 1'b0;  // Bubble flushed out
    end
  end

  assign wb_port_o.we   = lsu_we_q;
  assign wb_port_o.addr = lsu_waddr_q;
  assign wb_port_o.data = lsu_rdata_i;  // Load data arrives in WB

  // Handshake
  assign units_ready = alu_res_i.ready & mult_res_i.ready & lsu_ready_ex_i & wb_ready_i;

  // Branches finish in EX, so they never wait on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

/* source/ex_stage.sv */
`timescale 1ns/100ps

module ex_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  // Requests from ID
  input  ex_pkg::alu_req_t              alu_req_i,
  input  ex_pkg::mult_req_t             mult_req_i,
  // Writeback control and data
  input  logic                          csr_access_i,
  input  logic                          lsu_en_i,
  input  logic                          lsu_ready_ex_i,
  input  logic                          lsu_err_i,
  input  logic                          branch_in_ex_i,
  input  logic                          wb_ready_i,
  input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,
  input  logic [ex_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                          alu_we_i,
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] alu_waddr_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_i,
  // Write ports and handshake
  output ex_pkg::wb_port_t              fw_port_o,
  output ex_pkg::wb_port_t              wb_port_o,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o,
  // To IF and hazard logic
  output logic                          mult_multicycle_o,
  output logic                          branch_decision_o,
  output logic [ex_pkg::XLEN-1:0]       jump_target_o
);

  ex_pkg::unit_res_t alu_res;
  ex_pkg::unit_res_t mult_res;

  assign mult_multicycle_o = mult_res.multicycle;

  ////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////

  ex_alu alu_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_i             (alu_req_i),
    .res_o             (alu_res),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o)
  );

  ex_mult mult_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (mult_req_i),
    .ex_ready_i (ex_ready_o),  // Tells the multiplier its result left
    .res_o      (mult_res)
  );

  ////////////////////////////////////////
  // Write ports and handshake
  ////////////////////////////////////////

  ex_writeback writeback_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .alu_res_i       (alu_res),
    .mult_res_i      (mult_res),
    .alu_en_i        (alu_req_i.en),
    .mult_en_i       (mult_req_i.en),
    .csr_access_i    (csr_access_i),
    .lsu_en_i        (lsu_en_i),
    .lsu_ready_ex_i  (lsu_ready_ex_i),
    .lsu_err_i       (lsu_err_i),
    .branch_in_ex_i  (branch_in_ex_i),
    .wb_ready_i      (wb_ready_i),
    .csr_rdata_i     (csr_rdata_i),
    .lsu_rdata_i     (lsu_rdata_i),
    .alu_we_i        (alu_we_i),
    .regfile_we_i    (regfile_we_i),
    .alu_waddr_i     (alu_waddr_i),
    .regfile_waddr_i (regfile_waddr_i),
    .fw_port_o       (fw_port_o),
    .wb_port_o       (wb_port_o),
    .ex_ready_o      (ex_ready_o),
    .ex_valid_o      (ex_valid_o)
  );

endmodule

/* verif/ex_stage_tb.sv */
`timescale 1ns/100ps

module ex_stage_tb;

  localparam int CLK_PERIOD = 20;
  localparam int SETTLE     = 5;  // Sample point after the falling edge
  localparam int MAX_WAIT   = 1;  // High-half multiply adds one cycle

  // Which request inputs a row enables
  localparam logic [1:0] U_ALU = 2'd0;
  localparam logic [1:0] U_MUL = 2'd1;
  localparam logic [1:0] U_CSR = 2'd2;  // ALU, multiplier and CSR together
  localparam logic [1:0] U_LSU = 2'd3;

  typedef logic [ex_pkg::XLEN-1:0]       word_t;
  typedef logic [ex_pkg::REG_ADDR_W-1:0] addr_t;

  // One row of the stimulus table
  typedef struct packed {
    logic [1:0] unit;
    logic [6:0] op;            // Operation word for both views
    word_t      a;
    word_t      b;
    word_t      csr_data;
    logic       lsu_en;
    logic       lsu_we;
    logic       lsu_err;
    addr_t      lsu_addr;
    word_t      lsu_rdata;
    logic       wb_ready;
    logic       branch;        // Branch held in EX
    word_t      exp_data;      // Forward port data
    logic       exp_br;
    logic       exp_lsu_we;    // LSU port one cycle later
    addr_t      exp_lsu_addr;
  } entry_t;

  logic              clk;
  logic              rst_n;
  ex_pkg::alu_req_t  alu_req;
  ex_pkg::mult_req_t mult_req;
  logic              csr_access;
  logic              lsu_en;
  logic              lsu_ready_ex;
  logic              lsu_err;
  logic              branch_in_ex;
  logic              wb_ready;
  word_t             csr_rdata;
  word_t             lsu_rdata;
  logic              alu_we;
  logic              regfile_we;
  addr_t             alu_waddr;
  addr_t             regfile_waddr;
  ex_pkg::wb_port_t  fw_port;
  ex_pkg::wb_port_t  wb_port;
  logic              ex_ready;
  logic              ex_valid;
  logic              mult_multicycle;
  logic              branch_decision;
  word_t             jump_target;
  entry_t            rows[$];

  ex_stage ex_stage_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_req_i         (alu_req),
    .mult_req_i        (mult_req),
    .csr_access_i      (csr_access),
    .lsu_en_i          (lsu_en),
    .lsu_ready_ex_i    (lsu_ready_ex),
    .lsu_err_i         (lsu_err),
    .branch_in_ex_i    (branch_in_ex),
    .wb_ready_i        (wb_ready),
    .csr_rdata_i       (csr_rdata),
    .lsu_rdata_i       (lsu_rdata),
    .alu_we_i          (alu_we),
    .regfile_we_i      (regfile_we),
    .alu_waddr_i       (alu_waddr),
    .regfile_waddr_i   (regfile_waddr),
    .fw_port_o         (fw_port),
    .wb_port_o         (wb_port),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid),
    .mult_multicycle_o (mult_multicycle),
    .branch_decision_o (branch_decision),
    .jump_target_o     (jump_target)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(string name, word_t got, word_t exp);
    assert (got === exp) else begin
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
      abort_run();
    end
  endtask

  // High-half multiply ends when ex_ready_o rises
  task automatic wait_ex_ready();
    int cycles;
    cycles = 0;
    while (!ex_ready && cycles < MAX_WAIT) begin
      @(negedge clk);
      #(SETTLE);
      cycles++;
    end
    assert (ex_ready) else begin
      $display("ex_ready_o still low %0d cycles after a high-half multiply", MAX_WAIT);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // Row builders
  ////////////////////////////////////////

  function automatic entry_t alu_entry(logic [6:0] op, word_t a, word_t b, word_t exp_data,
                                       logic exp_br);
    entry_t e;
    e          = '0;
    e.unit     = U_ALU;
    e.op       = op;
    e.a        = a;
    e.b        = b;
    e.wb_ready = 1'b1;
    e.exp_data = exp_data;
    e.exp_br   = exp_br;
    return e;
  endfunction

  function automatic entry_t mul_entry(logic hi, logic a_signed, logic b_signed, word_t a,
                                       word_t b, word_t exp_data);
    entry_t e;
    e          = '0;
    e.unit     = U_MUL;
    e.op       = {hi, a_signed, b_signed, 4'b0000};  // Spare bits zero
    e.a        = a;
    e.b        = b;
    e.wb_ready = 1'b1;
    e.exp_data = exp_data;
    return e;
  endfunction

  // ADD on the ALU and a low-half multiply are both hidden by CSR data
  function automatic entry_t csr_entry(word_t csr_data);
    entry_t e;
    e          = alu_entry(ex_pkg::ALU_ADD, 32'd1, 32'd2, csr_data, 1'b0);
    e.unit     = U_CSR;
    e.csr_data = csr_data;
    return e;
  endfunction

  function automatic entry_t lsu_entry(logic en, logic we, logic err, addr_t addr, word_t rdata,
                                       logic wb_rdy, logic exp_we, addr_t exp_addr);
    entry_t e;
    e              = '0;
    e.unit         = U_LSU;
    e.lsu_en       = en;
    e.lsu_we       = we;
    e.lsu_err      = err;
    e.lsu_addr     = addr;
    e.lsu_rdata    = rdata;
    e.wb_ready     = wb_rdy;
    e.exp_lsu_we   = exp_we;
    e.exp_lsu_addr = exp_addr;
    return e;
  endfunction

  task automatic build_table();
    entry_t br_row;
    // Arithmetic, logic, shifts
    rows.push_back(alu_entry(ex_pkg::ALU_ADD, 32'h00001234, 32'h00000ff0, 32'h00002224, 1'b0));
    rows.push_back(alu_entry(ex_pkg::ALU_ADD, 32'hffffffff, 32'h00000002, 32'h00000001, 1'b0));
    rows.push_back(alu_entry(ex_pkg::ALU_SUB, 32'h00000005, 32'h00000007, 32'hfffffffe, 1'b0));
    rows.push_back(alu_entry(ex_pkg::ALU_AND, 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000, 1'b0));
    rows.push_back(alu_entry(ex_pkg::ALU_OR, 32'hf0f0f0f0, 32'h0f00000f, 32'hfff0f0ff, 1'b0));
    rows.push_back(alu_entry(ex_pkg::ALU_XOR, 32'haaaa5555, 32'hffff0000, 32'h55555555, 1'b0));
    rows.push_back(alu_entry(ex_pkg::ALU_SLL, 32'h00000003, 32'h00000024, 32'h00000030, 1'b0));
    rows.push_back(alu_entry(ex_pkg::ALU_SRL, 32'h80000000, 32'h0000001f, 32'h00000001, 1'b0));
    rows.push_back(alu_entry(ex_pkg::ALU_SRA, 32'h80000010, 32'h00000004, 32'hf8000001, 1'b0));
    // Compares put their bit in the result too
    rows.push_back(alu_entry(ex_pkg::ALU_EQ, 32'h00001234, 32'h00001234, 32'h00000001, 1'b1));
    rows.push_back(alu_entry(ex_pkg::ALU_NE, 32'h00001234, 32'h00001234, 32'h00000000, 1'b0));
    rows.push_back(alu_entry(ex_pkg::ALU_LTS, 32'hffffffff, 32'h00000001, 32'h00000001, 1'b1));
    rows.push_back(alu_entry(ex_pkg::ALU_LTU, 32'hffffffff, 32'h00000001, 32'h00000000, 1'b0));
    rows.push_back(alu_entry(ex_pkg::ALU_GES, 32'hffffffff, 32'h00000001, 32'h00000000, 1'b0));
    rows.push_back(alu_entry(ex_pkg::ALU_GES, 32'h00000005, 32'h00000005, 32'h00000001, 1'b1));
    rows.push_back(alu_entry(ex_pkg::ALU_GEU, 32'hffffffff, 32'h00000001, 32'h00000001, 1'b1));
    rows.push_back(alu_entry(ex_pkg::ALU_SLT, 32'h80000000, 32'h7fffffff, 32'h00000001, 1'b1));
    rows.push_back(alu_entry(ex_pkg::ALU_SLTU, 32'h80000000, 32'h7fffffff, 32'h00000000, 1'b0));
    // Branch in EX keeps ex_ready_o high under WB back-pressure
    br_row          = alu_entry(ex_pkg::ALU_GEU, 32'h00000001, 32'hffffffff, '0, 1'b0);
    br_row.wb_ready = 1'b0;
    br_row.branch   = 1'b1;
    rows.push_back(br_row);
    // Low-half multiply, then MULH, MULHU, MULHSU and min * min
    rows.push_back(mul_entry(1'b0, 1'b1, 1'b1, 32'hfffffffe, 32'h00000003, 32'hfffffffa));
    rows.push_back(mul_entry(1'b1, 1'b1, 1'b1, 32'hfffffffe, 32'h00000003, 32'hffffffff));
    rows.push_back(mul_entry(1'b1, 1'b0, 1'b0, 32'hffffffff, 32'hffffffff, 32'hfffffffe));
    rows.push_back(mul_entry(1'b1, 1'b1, 1'b0, 32'hffffffff, 32'hffffffff, 32'hffffffff));
    rows.push_back(mul_entry(1'b1, 1'b1, 1'b1, 32'h80000000, 32'h80000000, 32'h40000000));
    rows.push_back(csr_entry(32'hc5c50001));
    // LSU write, stall, load error, write, then idle
    rows.push_back(lsu_entry(1'b1, 1'b1, 1'b0, 6'h2a, 32'h11112222, 1'b1, 1'b1, 6'h2a));
    rows.push_back(lsu_entry(1'b1, 1'b1, 1'b0, 6'h15, 32'h33334444, 1'b0, 1'b1, 6'h2a));
    rows.push_back(lsu_entry(1'b1, 1'b1, 1'b1, 6'h07, 32'h55556666, 1'b1, 1'b0, 6'h2a));
    rows.push_back(lsu_entry(1'b1, 1'b1, 1'b0, 6'h3f, 32'h77778888, 1'b1, 1'b1, 6'h3f));
    rows.push_back(lsu_entry(1'b0, 1'b0, 1'b0, 6'h00, 32'h9999aaaa, 1'b1, 1'b0, 6'h3f));
  endtask

  task automatic apply_entry(entry_t e, addr_t tag);
    alu_req.en    = (e.unit == U_ALU) || (e.unit == U_CSR);
    alu_req.op    = e.op;
    alu_req.a     = e.a;
    alu_req.b     = e.b;
    alu_req.c     = ~e.b;  // Target unrelated to the result
    mult_req.en   = (e.unit == U_MUL) || (e.unit == U_CSR);
    mult_req.op   = e.op;
    mult_req.a    = e.a;
    mult_req.b    = e.b;
    csr_access    = (e.unit == U_CSR);
    csr_rdata     = e.csr_data;
    lsu_en        = e.lsu_en;
    lsu_ready_ex  = 1'b1;
    lsu_err       = e.lsu_err;
    branch_in_ex  = e.branch;
    wb_ready      = e.wb_ready;
    lsu_rdata     = e.lsu_rdata;
    alu_we        = (e.unit != U_LSU);
    alu_waddr     = tag;   // Row index marks the forward address
    regfile_we    = e.lsu_we;
    regfile_waddr = e.lsu_addr;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    entry_t            e;
    ex_pkg::mul_view_t view;
    logic              hi_mul;
    clk   = 1'b0;
    rst_n = 1'b0;
    apply_entry(lsu_entry(1'b0, 1'b0, 1'b0, '0, '0, 1'b1, 1'b0, '0), '0);  // Idle inputs
    build_table();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    #(SETTLE);
    check_value("wb_port_o.we", word_t'(wb_port.we), '0);
    check_value("mult_multicycle_o", word_t'(mult_multicycle), '0);
    check_value("ex_ready_o", word_t'(ex_ready), 32'd1);  // Multiplier idle

    foreach (rows[i]) begin
      e      = rows[i];
      view   = e.op;
      hi_mul = (e.unit == U_MUL) && view.hi;
      @(negedge clk);
      apply_entry(e, addr_t'(i));
      #(SETTLE);
      if (hi_mul) begin
        check_value("mult_multicycle_o", word_t'(mult_multicycle), 32'd1);
        check_value("ex_ready_o", word_t'(ex_ready), '0);
        wait_ex_ready();
      end else begin
        check_value("mult_multicycle_o", word_t'(mult_multicycle), '0);
        // Same cycle, a branch in EX overrides WB
        check_value("ex_ready_o", word_t'(ex_ready), word_t'(e.wb_ready | e.branch));
      end
      // Valid needs work present and WB ready
      check_value("ex_valid_o", word_t'(ex_valid),
                  word_t'(e.wb_ready & ((e.unit != U_LSU) | e.lsu_en)));
      check_value("fw_port_o.we", word_t'(fw_port.we), word_t'(e.unit != U_LSU));
      check_value("fw_port_o.addr", word_t'(fw_port.addr), word_t'(addr_t'(i)));
      if (e.unit != U_LSU) begin
        check_value("fw_port_o.data", fw_port.data, e.exp_data);
      end
      if (e.unit == U_ALU || e.unit == U_CSR) begin
        check_value("branch_decision_o", word_t'(branch_decision), word_t'(e.exp_br));
        check_value("jump_target_o", jump_target, ~e.b);
      end
      // EX/WB register moves at the rising edge
      @(posedge clk);
      #1;
      check_value("wb_port_o.we", word_t'(wb_port.we), word_t'(e.exp_lsu_we));
      check_value("wb_port_o.addr", word_t'(wb_port.addr), word_t'(e.exp_lsu_addr));
      check_value("wb_port_o.data", wb_port.data, e.lsu_rdata);
    end

    $display("No errors");
    $finish;
  end

endmodule

/* flist.f */
source/ex_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_writeback.sv
source/ex_stage.sv
verif/ex_stage_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ex_stage_tb -f flist.f -o ex_stage_tb_sim

# A failing run stops inside the simulation, so keep its output for the search
out=$(./obj_dir/ex_stage_tb_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "No errors"; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
